// ==== hdl/branch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the branch execution port.
// Command codes that are not listed decode as not taken.
// Condition codes that are not listed evaluate as never.
// FLUSH_CYCLES must be at least 1.
//////////////////////////////////////////////////////////////////////
package branch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [5:0]  tag_t;
	typedef logic [4:0]  flags_t;
	typedef logic [9:0]  swi_num_t;

	// Bit positions in flags_t
	localparam int FLAG_Z = 0;
	localparam int FLAG_S = 1;
	localparam int FLAG_C = 2;
	localparam int FLAG_O = 3;
	localparam int FLAG_P = 4;

	typedef enum logic [4:0] {
		CMD_JUMP_ABS = 5'h00,
		CMD_JUMP_REL = 5'h01,
		CMD_INTR_RET = 5'h02,
		CMD_IDTS     = 5'h03,
		CMD_SWI      = 5'h04
	} branch_cmd_t;

	typedef enum logic [3:0] {
		CC_ALWAYS = 4'h0,
		CC_NEVER  = 4'h1,
		CC_EQ     = 4'h2,
		CC_NE     = 4'h3,
		CC_LT     = 4'h4,
		CC_GE     = 4'h5,
		CC_LTU    = 4'h6,
		CC_GEU    = 4'h7,
		CC_NEG    = 4'h8,
		CC_PAR    = 4'h9
	} branch_cc_t;

	typedef enum logic [2:0] {
		RK_NONE = 3'd0,
		RK_JUMP = 3'd1,
		RK_INTR = 3'd2,
		RK_IDTS = 3'd3,
		RK_SWI  = 3'd4
	} redirect_kind_t;

	typedef enum logic [2:0] {
		RS_IDLE,
		RS_REQ,
		RS_WAIT_DROP,
		RS_FLUSH,
		RS_RESTART
	} redirect_state_t;

	typedef struct packed {
		branch_cmd_t cmd;
		branch_cc_t  cc;
		flags_t      flags;
		addr_t       source;
		addr_t       pc;
		tag_t        tag;
	} branch_op_t;

	typedef struct packed {
		redirect_kind_t kind;
		addr_t          target;
		swi_num_t       swi_num;
	} branch_res_t;

	typedef struct packed {
		redirect_kind_t kind;
		addr_t          target;
		tag_t           tag;
		swi_num_t       swi_num;
	} redirect_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} completion_t;

	// Pipeline drain time after a redirect
	localparam int FLUSH_CYCLES = 3;
	localparam int FLUSH_CNT_W  = $clog2(FLUSH_CYCLES + 1);

endpackage

// ==== hdl/branch_resolve.sv ====
//////////////////////////////////////////////////////////////////////
// Combinational branch resolver.
// Only the two jump commands look at the condition code. Interrupt
// return, IDTS and SWI always redirect, with the source as target.
// The target is meaningless when the kind is RK_NONE.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_resolve (
	input  branch_pkg::branch_op_t  op,
	output branch_pkg::branch_res_t res
);
	import branch_pkg::*;

	logic cond_true;

	always_comb begin
		case (op.cc)
			CC_ALWAYS: cond_true = 1'b1;
			CC_NEVER:  cond_true = 1'b0;
			CC_EQ:     cond_true = op.flags[FLAG_Z];
			CC_NE:     cond_true = !op.flags[FLAG_Z];
			CC_LT:     cond_true = op.flags[FLAG_S] ^ op.flags[FLAG_O];
			CC_GE:     cond_true = !(op.flags[FLAG_S] ^ op.flags[FLAG_O]);
			// Carry set means unsigned borrow
			CC_LTU:    cond_true = op.flags[FLAG_C];
			CC_GEU:    cond_true = !op.flags[FLAG_C];
			CC_NEG:    cond_true = op.flags[FLAG_S];
			CC_PAR:    cond_true = op.flags[FLAG_P];
			default:   cond_true = 1'b0;
		endcase
	end

	always_comb begin
		res.kind    = RK_NONE;
		res.target  = op.source;
		res.swi_num = swi_num_t'(op.source);
		case (op.cmd)
			CMD_JUMP_ABS: begin
				if (cond_true) begin
					res.kind = RK_JUMP;
				end
			end
			CMD_JUMP_REL: begin
				res.target = op.pc + op.source;
				if (cond_true) begin
					res.kind = RK_JUMP;
				end
			end
			CMD_INTR_RET: begin
				res.kind = RK_INTR;
			end
			CMD_IDTS: begin
				res.kind = RK_IDTS;
			end
			CMD_SWI: begin
				res.kind = RK_SWI;
			end
			default: begin
				res.kind = RK_NONE;
			end
		endcase
	end

endmodule

// ==== hdl/branch_port.sv ====
//////////////////////////////////////////////////////////////////////
// Registered branch execute stage.
// An op is taken when op_valid is high and lock is low; the issue
// stage must hold op stable while lock is high.
// Completion and redirect appear one cycle after acceptance.
// lock stays set from a redirecting op until restart.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_port (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    op_valid,
	input  branch_pkg::branch_op_t  op,
	input  branch_pkg::branch_res_t res,
	input  logic                    restart,
	output logic                    lock,
	output branch_pkg::completion_t completion,
	output logic                    redirect_valid,
	output branch_pkg::redirect_t   redirect
);
	import branch_pkg::*;

	logic accept;
	logic redirecting;
	logic stage_valid;
	tag_t stage_tag;

	assign accept      = op_valid && !lock;
	assign redirecting = res.kind != RK_NONE;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lock <= 1'b0;
		end else if (restart) begin
			lock <= 1'b0;
		end else if (accept && redirecting) begin
			lock <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			stage_valid    <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			stage_valid    <= accept;
			redirect_valid <= accept && redirecting;
		end
	end

	// Payload only loads on acceptance
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			stage_tag        <= op.tag;
			redirect.kind    <= res.kind;
			redirect.target  <= res.target;
			redirect.tag     <= op.tag;
			redirect.swi_num <= res.swi_num;
		end
	end

	assign completion.valid = stage_valid;
	assign completion.tag   = stage_tag;

	// A locked port must not complete anything in the next cycle
	a_no_completion_when_locked: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		lock |=> !completion.valid
	) else $error("completion while port was locked");

endmodule

// ==== hdl/redirect_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Redirect sequencer toward the front end.
// Four-phase handshake: req rises, ack rises, req falls, ack falls.
// Only one redirect is handled at a time; the port lock keeps new
// ones away until restart.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module redirect_fsm (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  redirect_valid,
	input  branch_pkg::redirect_t redirect,
	output logic                  redir_req,
	output branch_pkg::redirect_t redir_data,
	input  logic                  redir_ack,
	output logic                  start,
	input  logic                  done,
	output logic                  restart
);
	import branch_pkg::*;

	redirect_state_t state;
	redirect_state_t state_next;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= RS_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			RS_IDLE: begin
				if (redirect_valid) begin
					state_next = RS_REQ;
				end
			end
			RS_REQ: begin
				if (redir_ack) begin
					state_next = RS_WAIT_DROP;
				end
			end
			RS_WAIT_DROP: begin
				if (!redir_ack) begin
					state_next = RS_FLUSH;
				end
			end
			RS_FLUSH: begin
				if (done) begin
					state_next = RS_RESTART;
				end
			end
			default: begin
				state_next = RS_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK) begin
		if (state == RS_IDLE && redirect_valid) begin
			redir_data <= redirect;
		end
	end

	assign redir_req = state == RS_REQ;
	// Timer starts on the cycle ack is seen low again
	assign start     = state == RS_WAIT_DROP && !redir_ack;
	assign restart   = state == RS_RESTART;

	a_req_data_stable: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		redir_req ##1 redir_req |-> $stable(redir_data)
	) else $error("redir_data changed during request");

	a_redirect_when_idle: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		redirect_valid |-> state == RS_IDLE
	) else $error("redirect arrived while sequencer busy");

endmodule

// ==== hdl/flush_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline drain timer.
// start loads FLUSH_CYCLES; done pulses for one cycle when the
// count reaches zero. start is only legal while the count is zero.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module flush_timer (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic start,
	output logic done
);
	import branch_pkg::*;

	logic [FLUSH_CNT_W-1:0] count;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= count == FLUSH_CNT_W'(1);
			if (start) begin
				count <= FLUSH_CNT_W'(FLUSH_CYCLES);
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

	a_start_when_idle: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		start |-> count == '0
	) else $error("flush timer restarted while running");

endmodule

// ==== hdl/branch_unit_top.sv ====
//////////////////////////////////////////////////////////////////////
// Branch execution unit top.
// Issue side holds op while lock is high. The front end answers
// redir_req with a full four-phase redir_ack cycle.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_unit_top (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    op_valid,
	input  branch_pkg::branch_op_t  op,
	output logic                    lock,
	output branch_pkg::completion_t completion,
	output logic                    redir_req,
	output branch_pkg::redirect_t   redir_data,
	input  logic                    redir_ack
);
	import branch_pkg::*;

	branch_res_t res;
	redirect_t   redirect;
	logic        redirect_valid;
	logic        start;
	logic        done;
	logic        restart;

	branch_resolve i_branch_resolve (
		.op  (op),
		.res (res)
	);

	branch_port i_branch_port (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.op_valid       (op_valid),
		.op             (op),
		.res            (res),
		.restart        (restart),
		.lock           (lock),
		.completion     (completion),
		.redirect_valid (redirect_valid),
		.redirect       (redirect)
	);

	redirect_fsm i_redirect_fsm (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.redirect_valid (redirect_valid),
		.redirect       (redirect),
		.redir_req      (redir_req),
		.redir_data     (redir_data),
		.redir_ack      (redir_ack),
		.start          (start),
		.done           (done),
		.restart        (restart)
	);

	flush_timer i_flush_timer (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.start   (start),
		.done    (done)
	);

endmodule

// ==== tb/branch_unit_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench of the branch execution unit.
// Ops come from a table with hand-computed kinds and targets.
// The front end answers each request with random ack delays.
// Inputs change on the falling edge, where outputs are also sampled.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_unit_tb;
	import branch_pkg::*;

	typedef struct packed {
		branch_op_t     op;
		redirect_kind_t kind;
		addr_t          target;
	} entry_t;

	localparam int NUM_TESTS = 23;

	logic        iCLOCK;
	logic        inRESET;
	logic        op_valid;
	branch_op_t  op;
	logic        lock;
	completion_t completion;
	logic        redir_req;
	redirect_t   redir_data;
	logic        redir_ack;

	int          errors = 0;
	int          cyc = 0;
	int          ack_fall_cyc = 0;
	logic        lock_prev = 1'b0;
	logic [31:0] rng_state = 32'he910_05b2;
	tag_t        exp_tag_q[$];
	int          exp_cyc_q[$];
	redirect_t   exp_redir_q[$];

	// Flags are P O C S Z from left to right
	entry_t tests [NUM_TESTS] = '{
		'{'{CMD_JUMP_ABS, CC_NEVER,  5'b00000, 32'h0100, 32'h0040, 6'd1},  RK_NONE, 32'h0},
		'{'{CMD_JUMP_ABS, CC_EQ,     5'b00000, 32'h0200, 32'h0040, 6'd2},  RK_NONE, 32'h0},
		'{'{CMD_JUMP_ABS, CC_NE,     5'b00000, 32'h1200, 32'h0044, 6'd3},  RK_JUMP, 32'h1200},
		'{'{CMD_JUMP_REL, CC_NE,     5'b00001, 32'h0040, 32'h1008, 6'd23}, RK_NONE, 32'h0},
		'{'{CMD_JUMP_REL, CC_EQ,     5'b00001, 32'h0020, 32'h1000, 6'd4},  RK_JUMP, 32'h1020},
		'{'{CMD_JUMP_REL, CC_LT,     5'b01010, 32'h0030, 32'h1004, 6'd5},  RK_NONE, 32'h0},
		'{'{CMD_JUMP_REL, CC_LT,     5'b01000, 32'hffff_fff0, 32'h2000, 6'd6},
			RK_JUMP, 32'h1ff0},
		'{'{CMD_JUMP_ABS, CC_GE,     5'b00010, 32'h3000, 32'h0048, 6'd7},  RK_NONE, 32'h0},
		'{'{CMD_JUMP_ABS, CC_GE,     5'b01010, 32'h3000, 32'h004c, 6'd8},  RK_JUMP, 32'h3000},
		'{'{CMD_JUMP_ABS, CC_LTU,    5'b00000, 32'h3400, 32'h0050, 6'd9},  RK_NONE, 32'h0},
		'{'{CMD_JUMP_REL, CC_LTU,    5'b00100, 32'h0008, 32'h4000, 6'd10}, RK_JUMP, 32'h4008},
		'{'{CMD_JUMP_ABS, CC_GEU,    5'b00100, 32'h3800, 32'h0054, 6'd11}, RK_NONE, 32'h0},
		'{'{CMD_JUMP_ABS, CC_GEU,    5'b00000, 32'hb000, 32'h0058, 6'd12}, RK_JUMP, 32'hb000},
		'{'{CMD_JUMP_ABS, CC_NEG,    5'b00010, 32'h5000, 32'h005c, 6'd13}, RK_JUMP, 32'h5000},
		'{'{CMD_JUMP_ABS, CC_NEG,    5'b11101, 32'h5400, 32'h0060, 6'd14}, RK_NONE, 32'h0},
		'{'{CMD_JUMP_ABS, CC_PAR,    5'b01111, 32'h5800, 32'h0064, 6'd15}, RK_NONE, 32'h0},
		'{'{CMD_JUMP_REL, CC_PAR,    5'b10000, 32'h0100, 32'h6000, 6'd16}, RK_JUMP, 32'h6100},
		'{'{CMD_JUMP_ABS, CC_ALWAYS, 5'b00000, 32'h7000, 32'h0068, 6'd17}, RK_JUMP, 32'h7000},
		'{'{CMD_JUMP_ABS, branch_cc_t'(4'hf), 5'b11111, 32'h7400, 32'h006c, 6'd18},
			RK_NONE, 32'h0},
		'{'{branch_cmd_t'(5'h1f), CC_ALWAYS, 5'b00000, 32'h7800, 32'h0070, 6'd19},
			RK_NONE, 32'h0},
		'{'{CMD_INTR_RET, CC_NEVER,  5'b00000, 32'h8000, 32'h0074, 6'd20}, RK_INTR, 32'h8000},
		'{'{CMD_IDTS,     CC_EQ,     5'b00000, 32'h9000, 32'h0078, 6'd21}, RK_IDTS, 32'h9000},
		'{'{CMD_SWI,      CC_ALWAYS, 5'b00000, 32'ha3ff, 32'h007c, 6'd22}, RK_SWI,  32'ha3ff}
	};

	branch_unit_top i_branch_unit_top (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.op_valid   (op_valid),
		.op         (op),
		.lock       (lock),
		.completion (completion),
		.redir_req  (redir_req),
		.redir_data (redir_data),
		.redir_ack  (redir_ack)
	);

	task automatic flag_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	// Ack delay of 1 to 6 cycles
	function automatic int rand_delay();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return int'(rng_state % 6) + 1;
	endfunction

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		cyc <= cyc + 1;
	end

	// Completion order, lock gap and drain time
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			if (completion.valid) begin
				assert (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc
					&& exp_tag_q[0] == completion.tag)
				else flag_error($sformatf("unexpected completion tag %0d", completion.tag));
				if (exp_cyc_q.size() > 0) begin
					void'(exp_cyc_q.pop_front());
					void'(exp_tag_q.pop_front());
				end
			end else begin
				assert (exp_cyc_q.size() == 0 || exp_cyc_q[0] != cyc)
				else flag_error($sformatf("missing completion for tag %0d", exp_tag_q[0]));
			end
			assert (!(lock_prev && completion.valid))
			else flag_error("completion while lock was high");
			if (lock_prev && !lock) begin
				assert (cyc - ack_fall_cyc == FLUSH_CYCLES + 3)
				else flag_error($sformatf("lock fell %0d cycles after ack", cyc - ack_fall_cyc));
			end
			lock_prev = lock;
		end
	end

	// Front end
	initial begin : front_end
		redirect_t held;
		redirect_t exp;
		redir_ack = 1'b0;
		forever begin
			@(negedge iCLOCK);
			if (redir_req) begin
				held = redir_data;
				if (exp_redir_q.size() == 0) begin
					flag_error("redirect request without a redirecting op");
				end else begin
					exp = exp_redir_q.pop_front();
					assert (held.kind == exp.kind && held.target == exp.target
						&& held.tag == exp.tag && (exp.kind != RK_SWI
						|| held.swi_num == exp.swi_num))
					else flag_error($sformatf("tag %0d: redirect kind %0d target %h swi %h",
						exp.tag, held.kind, held.target, held.swi_num));
				end
				repeat (rand_delay()) begin
					@(negedge iCLOCK);
					assert (redir_req && redir_data == held)
					else flag_error("request dropped or changed before ack");
				end
				redir_ack = 1'b1;
				@(negedge iCLOCK);
				while (redir_req) begin
					@(negedge iCLOCK);
				end
				repeat (rand_delay()) @(negedge iCLOCK);
				redir_ack    = 1'b0;
				ack_fall_cyc = cyc;
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_TESTS * (FLUSH_CYCLES + 20) + 50) @(posedge iCLOCK);
		$display("Run timed out before all ops were retired");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin : stimulus
		inRESET  = 1'b0;
		op_valid = 1'b0;
		op       = '0;
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		assert (!lock && !redir_req && !completion.valid)
		else flag_error("outputs not idle after reset");

		for (int i = 0; i < NUM_TESTS; i++) begin
			op_valid = 1'b1;
			op       = tests[i].op;
			// Held while a redirect is outstanding
			while (lock) begin
				@(negedge iCLOCK);
			end
			exp_tag_q.push_back(tests[i].op.tag);
			exp_cyc_q.push_back(cyc + 1);
			if (tests[i].kind != RK_NONE) begin
				exp_redir_q.push_back(redirect_t'{tests[i].kind, tests[i].target,
					tests[i].op.tag, tests[i].op.source[9:0]});
			end
			@(negedge iCLOCK);
			op_valid = 1'b0;
			assert (lock == (tests[i].kind != RK_NONE))
			else flag_error($sformatf("tag %0d: lock is %b after acceptance",
				tests[i].op.tag, lock));
		end

		while (exp_tag_q.size() != 0 || exp_redir_q.size() != 0 || lock || redir_ack) begin
			@(negedge iCLOCK);
		end
		repeat (4) @(negedge iCLOCK);

		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
hdl/branch_pkg.sv
hdl/branch_resolve.sv
hdl/branch_port.sv
hdl/redirect_fsm.sv
hdl/flush_timer.sv
hdl/branch_unit_top.sv
tb/branch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - target: rtl
    files:
      - hdl/branch_pkg.sv
      - hdl/branch_resolve.sv
      - hdl/branch_port.sv
      - hdl/redirect_fsm.sv
      - hdl/flush_timer.sv
      - hdl/branch_unit_top.sv
  - target: test
    files:
      - tb/branch_unit_tb.sv
